// ==== src.f ====
snappy_pkg.sv
tag_decoder.sv
slice_window.sv
slice_decode.sv
token_chain.sv
length_accum.sv
snappy_preparser.sv
preparser_properties.sv
tb_preparser.sv

// ==== Bender.yml ====
package:
  name: snappy_preparser

sources:
  - snappy_pkg.sv
  - tag_decoder.sv
  - slice_window.sv
  - slice_decode.sv
  - token_chain.sv
  - length_accum.sv
  - snappy_preparser.sv
  - target: test
    files:
      - preparser_properties.sv
      - tb_preparser.sv

// ==== tb_preparser.sv ====
/* testbench for the snappy first-stage parser. builds random token streams,
   predicts every slice from the format rules and checks the DUT outputs */
`default_nettype none

module tb_preparser;

	localparam int ADDR_W = 24;
	localparam int NB     = snappy_pkg::BEAT_BYTES;
	localparam int NW     = snappy_pkg::WIN_BYTES;

	// one predicted slice
	typedef struct packed {
		logic [0:NW-1][7:0] data;
		logic [NB-1:0]      token_pos; // msb is byte 0
		logic               start_cont;
		logic [ADDR_W-1:0]  address;
	} slice_exp_t;

	logic                clk;
	logic                rst_n;
	snappy_pkg::beat_t   in_data;
	logic                in_valid;
	logic [0:NW-1][7:0]  slice_data;
	logic [NB-1:0]       token_pos;
	logic                start_cont;
	logic [ADDR_W-1:0]   address;
	logic                slice_valid;

	logic [31:0] lfsr;       // stimulus random state
	logic [7:0]  stream_q [$]; // token stream bytes
	bit          start_q  [$]; // 1 where a token starts
	int          dlen_q   [$]; // decompressed length at each start
	slice_exp_t  exp_q    [$];
	slice_exp_t  cur;
	int          errors;
	int          checks;
	int          cycles;
	int          limit;
	int          total;

	snappy_preparser #(
		.ADDR_W (ADDR_W)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_data     (in_data),
		.in_valid    (in_valid),
		.slice_data  (slice_data),
		.token_pos   (token_pos),
		.start_cont  (start_cont),
		.address     (address),
		.slice_valid (slice_valid)
	);

	bind snappy_preparser preparser_properties #(
		.ADDR_W (ADDR_W)
	) u_props (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.slice_valid (slice_valid),
		.start_cont  (start_cont),
		.address     (address)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// run limit reloaded by each test
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: slices still missing after %0d cycles", limit);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// random source and stream builder
	//////////////////////////////////////////////////
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // taps 32,22,2,1
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic put_byte(input logic [7:0] b, input bit s, input int d);
		stream_q.push_back(b);
		start_q.push_back(s);
		dlen_q.push_back(d);
	endtask

	// mix 0 copies only, 1 long literals with copies, 2 every kept tag
	task automatic add_token(input int mix);
		int kind;
		int n;
		if (mix == 0) begin
			kind = 3 + rand_bits(1);
		end else if (mix == 1) begin
			kind = 1 + rand_bits(2);
		end else begin
			kind = rand_bits(3) % 5;
		end
		case (kind)
			0: begin // short literal with length in tag
				n = rand_bits(6) % 60;
				put_byte({n[5:0], 2'b00}, 1'b1, n + 1);
			end
			1: begin // code 60
				n = rand_bits(8);
				put_byte(8'hf0, 1'b1, n + 1);
				put_byte(n[7:0], 1'b0, 0);
			end
			2: begin // code 61 with little-endian length
				n = rand_bits(mix == 1 ? 9 : 6);
				put_byte(8'hf4, 1'b1, n + 1);
				put_byte(n[7:0], 1'b0, 0);
				put_byte(n[15:8], 1'b0, 0);
			end
			3: begin
				n = rand_bits(3);
				put_byte({3'(rand_bits(3)), n[2:0], 2'b01}, 1'b1, n + 4);
				put_byte(8'(rand_bits(8)), 1'b0, 0);
				return;
			end
			default: begin
				n = rand_bits(6);
				put_byte({n[5:0], 2'b10}, 1'b1, n + 1);
				put_byte(8'(rand_bits(8)), 1'b0, 0);
				put_byte(8'(rand_bits(8)), 1'b0, 0);
				return;
			end
		endcase
		repeat (n + 1) put_byte(8'(rand_bits(8)), 1'b0, 0); // literal content
	endtask

	//////////////////////////////////////////////////
	// one test with reset, stream, model, drive and drain
	//////////////////////////////////////////////////
	task automatic run_test(input string name, input int mix, input int nslices);
		int                gaps [$];
		int                idle_total;
		int                errs_before;
		logic [ADDR_W-1:0] addr;
		slice_exp_t        e;
		snappy_pkg::beat_t beat;
		stream_q.delete();
		start_q.delete();
		dlen_q.delete();
		while (stream_q.size() < nslices * NB + 2) add_token(mix);
		while (stream_q.size() < (nslices + 1) * NB) put_byte(8'h00, 1'b0, 0); // tail pad
		addr = '0;
		for (int k = 0; k < nslices; k++) begin
			for (int i = 0; i < NW; i++) e.data[i] = stream_q[NB*k+i];
			for (int i = 0; i < NB; i++) e.token_pos[NB-1-i] = start_q[NB*k+i];
			e.start_cont = !start_q[NB*k]; // carry is nonzero when byte 0 is inside a token
			e.address    = addr;
			for (int i = 0; i < NB; i++) begin
				if (start_q[NB*k+i]) addr = addr + ADDR_W'(dlen_q[NB*k+i]);
			end
			exp_q.push_back(e);
		end
		idle_total = 0;
		for (int b = 0; b <= nslices; b++) begin
			gaps.push_back(rand_bits(1) ? rand_bits(2) : 0);
			idle_total += gaps[b];
		end
		errs_before = errors + i_dut.u_props.fails;
		limit  = 3 * (nslices + 1 + idle_total) + 20;
		cycles = 0;
		rst_n    = 1'b0; // also exercises a mid-run reset
		in_valid = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		rst_n = 1'b1;
		for (int b = 0; b <= nslices; b++) begin
			for (int i = 0; i < NB; i++) beat[i] = stream_q[NB*b+i];
			in_data  = beat;
			in_valid = 1'b1;
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			repeat (gaps[b]) begin
				@(posedge clk);
				#1;
			end
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
		$display("%s: %0d slices, %0d errors", name, nslices,
			errors + i_dut.u_props.fails - errs_before);
	endtask

	// compare on the falling edge when outputs are settled
	always @(negedge clk) begin
		if (rst_n && slice_valid) begin
			if (exp_q.size() == 0) begin
				$display("slice at time %0t arrived with no predicted slice left", $time);
				errors++;
			end else begin
				cur = exp_q.pop_front();
				checks++;
				a_data: assert (slice_data == cur.data) else begin
					$display("CHECK FAILED @%0t: slice_data %h, expected %h", $time,
						slice_data, cur.data);
					errors++;
				end
				a_pos: assert (token_pos == cur.token_pos) else begin
					$display("CHECK FAILED @%0t: token_pos %h, expected %h", $time,
						token_pos, cur.token_pos);
					errors++;
				end
				a_cont: assert (start_cont == cur.start_cont) else begin
					$display("CHECK FAILED @%0t: start_cont %b, expected %b", $time,
						start_cont, cur.start_cont);
					errors++;
				end
				a_addr: assert (address == cur.address) else begin
					$display("CHECK FAILED @%0t: address %0d, expected %0d", $time,
						address, cur.address);
					errors++;
				end
			end
		end
	end

	initial begin
		lfsr     = 32'h2a172b45;
		errors   = 0;
		checks   = 0;
		cycles   = 0;
		limit    = 100;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		#1;
		run_test("copy tokens", 0, 40);
		run_test("long literals", 1, 300);
		run_test("mixed stream", 2, 80);
		total = errors + i_dut.u_props.fails;
		$display("tests: 3, slices checked: %0d, errors: %0d", checks, total);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== preparser_properties.sv ====
/* timing and reset properties of the parser top level,
   attached to snappy_preparser with bind */
`default_nettype none

module preparser_properties #(
	parameter int ADDR_W = 24
) (
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input logic              slice_valid,
	input logic              start_cont,
	input logic [ADDR_W-1:0] address
);

	int   fails = 0; // failed assertion count
	logic seen;      // a beat arrived since reset
	logic first;     // next slice is the first after reset

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen  <= 1'b0;
			first <= 1'b1;
		end else begin
			if (in_valid) seen <= 1'b1;
			if (slice_valid) first <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// reset and latency
	//////////////////////////////////////////////////
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !slice_valid)
		else begin $error("slice_valid high just after reset"); fails++; end

	// every beat after the first gives a slice 4 cycles later
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && seen |-> ##4 slice_valid)
		else begin $error("slice missing 4 cycles after a beat"); fails++; end

	a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
		slice_valid |-> $past(in_valid && seen, 4))
		else begin $error("slice without a matching second beat"); fails++; end

	a_fresh_start: assert property (@(posedge clk) disable iff (!rst_n)
		slice_valid && first |-> address == '0 && !start_cont)
		else begin $error("first slice after reset not at address zero"); fails++; end

endmodule

`default_nettype wire

// ==== snappy_preparser.sv ====
/* top of the first-stage snappy parser: window, decode, chain, accumulate.
   slice_valid for beat k follows the in_valid of beat k+1 by four cycles */
`default_nettype none

module snappy_preparser #(
	parameter int ADDR_W = 24 // width of the decompressed address
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  snappy_pkg::beat_t                      in_data,
	input  logic                                   in_valid,
	output logic [0:snappy_pkg::WIN_BYTES-1][7:0]  slice_data,
	output logic [snappy_pkg::BEAT_BYTES-1:0]      token_pos,  // msb is byte 0
	output logic                                   start_cont,
	output logic [ADDR_W-1:0]                      address,
	output logic                                   slice_valid
);

	snappy_pkg::window_t       win;   // stage 1
	snappy_pkg::decode_slice_t dec;   // stage 2
	snappy_pkg::chain_slice_t  chain; // stage 3

	slice_window u_slice_window (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.in_valid (in_valid),
		.win      (win)
	);

	slice_decode u_slice_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.win   (win),
		.dec   (dec)
	);

	token_chain u_token_chain (
		.clk   (clk),
		.rst_n (rst_n),
		.dec   (dec),
		.chain (chain)
	);

	length_accum #(
		.ADDR_W (ADDR_W)
	) u_length_accum (
		.clk         (clk),
		.rst_n       (rst_n),
		.chain       (chain),
		.slice_data  (slice_data),
		.token_pos   (token_pos),
		.start_cont  (start_cont),
		.address     (address),
		.slice_valid (slice_valid)
	);

endmodule

`default_nettype wire

// ==== length_accum.sv ====
/* running decompressed address. each slice is tagged with the total from
   before it, then the lengths of its own marked tokens are added on */
`default_nettype none

module length_accum #(
	parameter int ADDR_W = 24
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  snappy_pkg::chain_slice_t               chain,
	output logic [0:snappy_pkg::WIN_BYTES-1][7:0]  slice_data,
	output logic [snappy_pkg::BEAT_BYTES-1:0]      token_pos,
	output logic                                   start_cont,
	output logic [ADDR_W-1:0]                      address,
	output logic                                   slice_valid
);

	localparam int SUM_W = snappy_pkg::LEN_W + 4; // 16 terms of LEN_W bits
	localparam int NB    = snappy_pkg::BEAT_BYTES;

	typedef logic [SUM_W-1:0] sum_t;

	sum_t              l0 [NB];   // masked lengths
	sum_t              l1 [NB/2];
	sum_t              l2 [NB/4];
	sum_t              l3 [NB/8];
	sum_t              slice_sum;
	logic [ADDR_W-1:0] total;     // sum over all earlier slices

	// 4-level adder tree
	always_comb begin
		for (int i = 0; i < NB; i++) begin
			l0[i] = chain.token_pos[NB-1-i] ? sum_t'(chain.dlen[i]) : '0;
		end
		for (int i = 0; i < NB/2; i++) begin
			l1[i] = l0[2*i] + l0[2*i+1];
		end
		for (int i = 0; i < NB/4; i++) begin
			l2[i] = l1[2*i] + l1[2*i+1];
		end
		for (int i = 0; i < NB/8; i++) begin
			l3[i] = l2[2*i] + l2[2*i+1];
		end
		slice_sum = l3[0] + l3[1];
	end

	always_ff @(posedge clk) begin
		if (chain.valid) begin
			slice_data <= chain.data;
			token_pos  <= chain.token_pos;
			start_cont <= chain.start_cont;
			address    <= total; // total before this slice
		end
		if (!rst_n) begin
			total       <= '0;
			slice_valid <= 1'b0;
		end else begin
			slice_valid <= chain.valid;
			if (chain.valid) begin
				total <= total + ADDR_W'(slice_sum); // wraps at ADDR_W
			end
		end
	end

endmodule

`default_nettype wire

// ==== token_chain.sv ====
/* picks the real token starts out of the sixteen per-byte guesses.
   the skip carry says where the first token of the slice begins */
`default_nettype none

module token_chain (
	input  logic                      clk,
	input  logic                      rst_n,
	input  snappy_pkg::decode_slice_t dec,
	output snappy_pkg::chain_slice_t  chain
);

	typedef logic [snappy_pkg::SKIP_W-1:0] skip_t;

	skip_t                            skip;       // offset of next start from byte 0
	skip_t                            skip_nxt;   // carry for following slice
	skip_t                            next_start; // walking pointer
	logic [snappy_pkg::BEAT_BYTES-1:0] starts;

	//////////////////////////////////////////////////
	// walk the starts
	//////////////////////////////////////////////////
	// each confirmed start hops one token size further; anything
	// beyond byte 15 is literal content or header spilling over
	always_comb begin
		next_start = skip;
		starts     = '0;
		for (int i = 0; i < snappy_pkg::BEAT_BYTES; i++) begin
			if (next_start == skip_t'(i)) begin
				starts[snappy_pkg::BEAT_BYTES-1-i] = 1'b1; // msb is byte 0
				next_start = skip_t'(i) + dec.pos[i].size;
			end
		end
		// with no start in the slice this is old skip minus 16
		skip_nxt = next_start - skip_t'(snappy_pkg::BEAT_BYTES);
	end

	//////////////////////////////////////////////////
	// stage register and carry
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (dec.valid) begin
			chain.data       <= dec.data;
			chain.token_pos  <= starts;
			chain.start_cont <= (skip != '0); // opens inside an earlier token
			for (int i = 0; i < snappy_pkg::BEAT_BYTES; i++) begin
				chain.dlen[i] <= dec.pos[i].dlen;
			end
		end
		if (!rst_n) begin
			chain.valid <= 1'b0;
			skip        <= '0; // stream starts on a token
		end else begin
			chain.valid <= dec.valid;
			if (dec.valid) begin
				skip <= skip_nxt; // idle cycles hold the carry
			end
		end
	end

endmodule

`default_nettype wire

// ==== slice_decode.sv ====
/* one decode stage: every byte of the slice is decoded as if it opened a token.
   positions 14 and 15 read into the lookahead bytes of the window */
`default_nettype none

module slice_decode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  snappy_pkg::window_t       win,
	output snappy_pkg::decode_slice_t dec
);

	snappy_pkg::byte_decode_t [0:snappy_pkg::BEAT_BYTES-1] lane; // raw decoder outputs

	for (genvar i = 0; i < snappy_pkg::BEAT_BYTES; i++) begin : g_lane
		tag_decoder u_tag_decoder (
			.bytes ({win.data[i], win.data[i+1], win.data[i+2]}),
			.dec   (lane[i])
		);
	end

	always_ff @(posedge clk) begin
		if (win.valid) begin
			dec.data <= win.data;
			dec.pos  <= lane;
		end
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= win.valid;
		end
	end

endmodule

`default_nettype wire

// ==== slice_window.sv ====
/* beat buffer with two-byte lookahead. a beat is only emitted once the next
   beat shows up, so each window carries the first two bytes of its successor */
`default_nettype none

module slice_window (
	input  logic                clk,
	input  logic                rst_n,
	input  snappy_pkg::beat_t   in_data,
	input  logic                in_valid,
	output snappy_pkg::window_t win
);

	snappy_pkg::beat_t prev_beat; // last accepted beat, waits for lookahead
	logic              seen;      // at least one beat since reset

	// payload, loaded on accepted beats only
	always_ff @(posedge clk) begin
		if (in_valid) begin
			prev_beat <= in_data;
		end
		if (in_valid && seen) begin
			win.data <= {prev_beat, in_data[0], in_data[1]}; // beat k + head of k+1
		end
	end

	// control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen      <= 1'b0;
			win.valid <= 1'b0;
		end else begin
			win.valid <= in_valid & seen; // first beat alone gives nothing
			if (in_valid) begin
				seen <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tag_decoder.sv ====
/* decodes the token that would start at one byte position, given the tag and
   the two bytes after it. only meaningful where the chain confirms a start */
`default_nettype none

module tag_decoder (
	input  logic [23:0]              bytes, // tag in [23:16] then two following bytes
	output snappy_pkg::byte_decode_t dec
);

	typedef logic [snappy_pkg::LEN_W-1:0]  len_t;
	typedef logic [snappy_pkg::SKIP_W-1:0] size_t;

	logic [7:0]            tag;
	logic [7:0]            ext_lo;  // first byte after tag
	logic [7:0]            ext_hi;  // second byte after tag
	logic [5:0]            lfield;  // length field / code in tag[7:2]
	snappy_pkg::tag_kind_e kind;

	assign tag    = bytes[23:16];
	assign ext_lo = bytes[15:8];
	assign ext_hi = bytes[7:0];
	assign lfield = tag[7:2];

	//////////////////////////////////////////////////
	// classify
	//////////////////////////////////////////////////
	always_comb begin
		case (tag[1:0])
			2'b00: begin
				if (lfield < 6'd60) begin
					kind = snappy_pkg::TAG_LITERAL;
				end else if (lfield == 6'd60) begin
					kind = snappy_pkg::TAG_LIT_EXT1;
				end else begin
					kind = snappy_pkg::TAG_LIT_EXT2; // 62/63 not generated
				end
			end
			2'b01:   kind = snappy_pkg::TAG_COPY1;
			default: kind = snappy_pkg::TAG_COPY2; // tag 11 never appears
		endcase
	end

	//////////////////////////////////////////////////
	// token size and decompressed length
	//////////////////////////////////////////////////
	always_comb begin
		dec.kind = kind;
		case (kind)
			snappy_pkg::TAG_LITERAL: begin
				dec.size = size_t'(lfield) + size_t'(2);  // 1 header + L+1 content
				dec.dlen = len_t'(lfield) + len_t'(1);
			end
			snappy_pkg::TAG_LIT_EXT1: begin
				dec.size = size_t'(ext_lo) + size_t'(3);  // 2 header + b+1 content
				dec.dlen = len_t'(ext_lo) + len_t'(1);
			end
			snappy_pkg::TAG_LIT_EXT2: begin
				dec.size = size_t'({ext_hi, ext_lo}) + size_t'(4); // 3 header bytes
				dec.dlen = len_t'({ext_hi, ext_lo}) + len_t'(1);
			end
			snappy_pkg::TAG_COPY1: begin
				dec.size = size_t'(2);
				dec.dlen = len_t'(tag[4:2]) + len_t'(4); // copy length 4..11
			end
			default: begin // copy with 2-byte offset
				dec.size = size_t'(3);
				dec.dlen = len_t'(lfield) + len_t'(1);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== snappy_pkg.sv ====
/* shared sizes, tag opcodes and stage records for the snappy first-stage parser.
   every stage module takes its types from here by scoped name */
`default_nettype none

package snappy_pkg;

	//////////////////////////////////////////////////
	// beat and window geometry
	//////////////////////////////////////////////////
	localparam int BEAT_BYTES = 16; // bytes per input beat
	localparam int LOOKAHEAD  = 2;  // lookahead for a 3-byte header
	localparam int WIN_BYTES  = BEAT_BYTES + LOOKAHEAD;

	localparam int LEN_W  = 17; // literal up to 65536 bytes
	localparam int SKIP_W = 17; // header plus content can run past several beats

	// token classes actually produced by the stream
	typedef enum logic [2:0] {
		TAG_LITERAL,  // length 0..59 in tag byte
		TAG_LIT_EXT1, // code 60 with one length byte
		TAG_LIT_EXT2, // code 61 with two little-endian length bytes
		TAG_COPY1,    // tag 01
		TAG_COPY2     // tag 10
	} tag_kind_e;

	typedef logic [0:BEAT_BYTES-1][7:0] beat_t; // index 0 sits in the top bits

	// 16 bytes of one beat plus the head of the next
	typedef struct packed {
		logic [0:WIN_BYTES-1][7:0] data;
		logic                      valid;
	} window_t;

	// decode of the token assumed to start at one byte
	typedef struct packed {
		tag_kind_e         kind;
		logic [SKIP_W-1:0] size; // header + literal content
		logic [LEN_W-1:0]  dlen; // bytes it produces when decompressed
	} byte_decode_t;

	typedef struct packed {
		logic [0:WIN_BYTES-1][7:0]         data;
		byte_decode_t [0:BEAT_BYTES-1]     pos;   // one per byte position
		logic                              valid;
	} decode_slice_t;

	typedef struct packed {
		logic [0:WIN_BYTES-1][7:0]         data;
		logic [BEAT_BYTES-1:0]             token_pos;  // msb is byte 0
		logic                              start_cont; // slice opens inside a token
		logic [0:BEAT_BYTES-1][LEN_W-1:0]  dlen;
		logic                              valid;
	} chain_slice_t;

endpackage

`default_nettype wire
